// File: lsu_config.svh
// size and depth macros for the load/store unit, included by the package, RTL and testbench
`ifndef LSU_CONFIG_SVH
`define LSU_CONFIG_SVH

//////////////////////////////
// bus widths
//////////////////////////////
`define LSU_DATA_W 32  // data word width
`define LSU_ADDR_W 32  // byte address width
`define LSU_BE_W   4   // one enable per byte lane

//////////////////////////////
// outstanding transactions
//////////////////////////////
`define LSU_DEPTH  2   // max accesses in flight on the bus
`define LSU_CNT_W  2   // counter must hold 0..LSU_DEPTH

`endif

// File: lsu_pkg.sv
// shared enums and packed structs of the load/store unit, imported by the RTL and testbench
`include "lsu_config.svh"

package lsu_pkg;

  //////////////////////////////
  // encodings
  //////////////////////////////

  // access size, byte takes the top code
  typedef enum logic [1:0] {
    DT_WORD = 2'b00,
    DT_HALF = 2'b01,
    DT_BYTE = 2'b10
  } lsu_dtype_e;

  // how the upper bits of a narrow load are filled
  typedef enum logic [1:0] {
    EXT_ZERO = 2'b00,
    EXT_SIGN = 2'b01,
    EXT_ONES = 2'b10
  } lsu_ext_e;

  //////////////////////////////
  // port bundles
  //////////////////////////////

  // one access as presented by the execute stage
  typedef struct packed {
    logic                   we;        // store when set
    lsu_dtype_e             dtype;
    lsu_ext_e               ext;
    logic [`LSU_DATA_W-1:0] wdata;     // store data, low lanes
    logic [`LSU_ADDR_W-1:0] op_a;      // base
    logic [`LSU_ADDR_W-1:0] op_b;      // offset
    logic                   use_incr;  // address is op_a + op_b
  } lsu_ex_req_t;

  // OBI address phase
  typedef struct packed {
    logic [`LSU_ADDR_W-1:0] addr;
    logic                   we;
    logic [`LSU_BE_W-1:0]   be;
    logic [`LSU_DATA_W-1:0] wdata;  // already rotated onto the enabled lanes
  } lsu_bus_req_t;

  // what the response side needs to align the read data
  typedef struct packed {
    lsu_dtype_e dtype;
    logic [1:0] offset;  // low address bits
    lsu_ext_e   ext;
    logic       we;      // stores return no load data
  } lsu_wb_ctrl_t;

endpackage

// File: lsu_req_gen.sv
// combinational request side of the load/store unit, builds the OBI address phase from an EX access
`include "lsu_config.svh"

module lsu_req_gen
  import lsu_pkg::*;
(
  input  logic         ex_valid_i,       // execute stage has an access
  input  lsu_ex_req_t  ex_req_i,
  input  logic         cnt_full_i,       // LSU_DEPTH accesses already in flight
  output logic         bus_req_o,
  output lsu_bus_req_t bus_req_fields_o,
  output lsu_wb_ctrl_t wb_ctrl_next_o    // control handed to the response side
);

  logic [`LSU_ADDR_W-1:0] addr;    // effective byte address
  logic [1:0]             offset;  // lane of the first byte
  logic [`LSU_BE_W-1:0]   be;
  logic [`LSU_DATA_W-1:0] wdata;   // rotated store data

  //////////////////////////////
  // address
  //////////////////////////////
  assign addr   = ex_req_i.use_incr ? (ex_req_i.op_a + ex_req_i.op_b) : ex_req_i.op_a;
  assign offset = addr[1:0];

  //////////////////////////////
  // byte enables
  //////////////////////////////
  // addresses arrive naturally aligned, so a halfword only sits at offset 0 or 2
  always_comb begin
    case (ex_req_i.dtype)
      DT_WORD: be = 4'b1111;
      DT_HALF: be = offset[1] ? 4'b1100 : 4'b0011;
      default: begin  // byte
        case (offset)
          2'b00:   be = 4'b0001;
          2'b01:   be = 4'b0010;
          2'b10:   be = 4'b0100;
          default: be = 4'b1000;
        endcase
      end
    endcase
  end

  //////////////////////////////
  // store data lanes
  //////////////////////////////
  // rotate left by whole bytes so byte 0 of the register lands on lane offset
  always_comb begin
    case (offset)
      2'b00:   wdata = ex_req_i.wdata;
      2'b01:   wdata = {ex_req_i.wdata[23:0], ex_req_i.wdata[31:24]};
      2'b10:   wdata = {ex_req_i.wdata[15:0], ex_req_i.wdata[31:16]};
      default: wdata = {ex_req_i.wdata[7:0], ex_req_i.wdata[31:8]};
    endcase
  end

  //////////////////////////////
  // outputs
  //////////////////////////////
  // no new request while the in-flight window is full
  assign bus_req_o = ex_valid_i && !cnt_full_i;

  assign bus_req_fields_o.addr  = addr;
  assign bus_req_fields_o.we    = ex_req_i.we;
  assign bus_req_fields_o.be    = be;
  assign bus_req_fields_o.wdata = wdata;

  assign wb_ctrl_next_o.dtype  = ex_req_i.dtype;
  assign wb_ctrl_next_o.offset = offset;       // picks the read lane later
  assign wb_ctrl_next_o.ext    = ex_req_i.ext;
  assign wb_ctrl_next_o.we     = ex_req_i.we;

endmodule

// File: lsu_txn_ctrl.sv
// outstanding-transaction counter and EX/WB handshake logic of the load/store unit
`include "lsu_config.svh"

module lsu_txn_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic ex_valid_i,     // execute stage has an access
  input  logic bus_req_i,      // request currently driven on the bus
  input  logic bus_gnt_i,
  input  logic bus_rvalid_i,
  output logic cnt_full_o,     // no room for another transaction
  output logic ex_ready_o,
  output logic wb_ready_o,
  output logic busy_o,
  output logic ctrl_update_o   // EX access moves to WB this cycle
);

  logic [`LSU_CNT_W-1:0] cnt_q;     // accesses granted but not yet answered
  logic [`LSU_CNT_W-1:0] cnt_next;
  logic                  count_up;
  logic                  count_down;

  assign count_up   = bus_req_i && bus_gnt_i;  // address phase done
  assign count_down = bus_rvalid_i;            // response phase done

  //////////////////////////////
  // counter
  //////////////////////////////
  always_comb begin
    case ({count_up, count_down})
      2'b10:   cnt_next = cnt_q + 1'b1;
      2'b01:   cnt_next = cnt_q - 1'b1;
      default: cnt_next = cnt_q;  // idle, or one in and one out
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_next;
    end
  end

  assign cnt_full_o = (cnt_q == `LSU_CNT_W'(`LSU_DEPTH));

  //////////////////////////////
  // readiness
  //////////////////////////////
  // WB is free when empty, otherwise it frees up with the awaited response
  assign wb_ready_o = (cnt_q == '0) ? 1'b1 : bus_rvalid_i;

  // EX and WB advance in lock step, so with anything in flight
  // the response has to arrive in the same cycle as the grant
  always_comb begin
    if (!ex_valid_i) begin
      ex_ready_o = 1'b1;                               // nothing to hold
    end else if (cnt_q == '0) begin
      ex_ready_o = count_up;
    end else if (cnt_q == `LSU_CNT_W'(1)) begin
      ex_ready_o = count_up && bus_rvalid_i;
    end else begin
      ex_ready_o = bus_rvalid_i;                       // full, wait on a response
    end
  end

  assign ctrl_update_o = ex_ready_o && ex_valid_i;
  assign busy_o        = (cnt_q != '0) || bus_req_i;  // in flight or about to be

endmodule

// File: lsu_load_align.sv
// response side of the load/store unit, aligns and extends load data and holds the last result
`include "lsu_config.svh"

module lsu_load_align
  import lsu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   ctrl_update_i,   // new access enters WB
  input  lsu_wb_ctrl_t           wb_ctrl_next_i,
  input  logic                   bus_rvalid_i,
  input  logic [`LSU_DATA_W-1:0] bus_rdata_i,
  output logic [`LSU_DATA_W-1:0] rdata_o
);

  lsu_wb_ctrl_t           wb_ctrl_q;   // control of the access awaiting its response
  logic [`LSU_DATA_W-1:0] rdata_shift; // addressed lane moved down to bit 0
  logic [`LSU_DATA_W-1:0] rdata_ext;   // aligned and filled result
  logic [`LSU_DATA_W-1:0] rdata_q;     // last load result
  logic                   msb;         // top bit of the selected half or byte
  logic                   fill;        // value of the upper bits

  //////////////////////////////
  // writeback control
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ctrl_q <= '0;
    end else if (ctrl_update_i) begin
      wb_ctrl_q <= wb_ctrl_next_i;  // captured as the access is accepted
    end
  end

  //////////////////////////////
  // lane select and extension
  //////////////////////////////
  // shift right by offset bytes, the wanted byte or half then sits in the low bits
  assign rdata_shift = bus_rdata_i >> {wb_ctrl_q.offset, 3'b000};

  always_comb begin
    case (wb_ctrl_q.dtype)
      DT_HALF: msb = rdata_shift[15];
      default: msb = rdata_shift[7];
    endcase
  end

  always_comb begin
    case (wb_ctrl_q.ext)
      EXT_SIGN: fill = msb;
      EXT_ONES: fill = 1'b1;  // one-filled
      default:  fill = 1'b0;
    endcase
  end

  always_comb begin
    case (wb_ctrl_q.dtype)
      DT_HALF: rdata_ext = {{16{fill}}, rdata_shift[15:0]};
      DT_BYTE: rdata_ext = {{24{fill}}, rdata_shift[7:0]};
      default: rdata_ext = bus_rdata_i;  // word, passed as is
    endcase
  end

  //////////////////////////////
  // result hold
  //////////////////////////////
  // only loads update the held value, a store response leaves it alone
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (bus_rvalid_i && !wb_ctrl_q.we) begin
      rdata_q <= rdata_ext;
    end
  end

  // live data in the response cycle, the held value otherwise
  assign rdata_o = bus_rvalid_i ? rdata_ext : rdata_q;

endmodule

// File: lsu_top.sv
// top level of the load/store unit, connects the execute port to an OBI data bus
`include "lsu_config.svh"

module lsu_top
  import lsu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,

  // execute stage
  input  logic                   ex_valid_i,
  input  lsu_ex_req_t            ex_req_i,
  output logic                   ex_ready_o,

  // OBI address phase
  output logic                   bus_req_o,
  output lsu_bus_req_t           bus_req_fields_o,
  input  logic                   bus_gnt_i,

  // OBI response phase
  input  logic                   bus_rvalid_i,
  input  logic [`LSU_DATA_W-1:0] bus_rdata_i,

  // writeback and status
  output logic [`LSU_DATA_W-1:0] rdata_o,
  output logic                   wb_ready_o,
  output logic                   busy_o
);

  logic         trans_valid;   // request as driven on the bus
  logic         cnt_full;
  logic         ctrl_update;
  lsu_wb_ctrl_t wb_ctrl_next;

  assign bus_req_o = trans_valid;

  //////////////////////////////
  // request side
  //////////////////////////////
  lsu_req_gen u_req_gen (
    .ex_valid_i       (ex_valid_i),
    .ex_req_i         (ex_req_i),
    .cnt_full_i       (cnt_full),
    .bus_req_o        (trans_valid),
    .bus_req_fields_o (bus_req_fields_o),
    .wb_ctrl_next_o   (wb_ctrl_next)
  );

  lsu_txn_ctrl u_txn_ctrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .ex_valid_i    (ex_valid_i),
    .bus_req_i     (trans_valid),
    .bus_gnt_i     (bus_gnt_i),
    .bus_rvalid_i  (bus_rvalid_i),
    .cnt_full_o    (cnt_full),
    .ex_ready_o    (ex_ready_o),
    .wb_ready_o    (wb_ready_o),
    .busy_o        (busy_o),
    .ctrl_update_o (ctrl_update)
  );

  //////////////////////////////
  // response side
  //////////////////////////////
  lsu_load_align u_load_align (
    .clk            (clk),
    .rst_n          (rst_n),
    .ctrl_update_i  (ctrl_update),
    .wb_ctrl_next_i (wb_ctrl_next),
    .bus_rvalid_i   (bus_rvalid_i),
    .bus_rdata_i    (bus_rdata_i),
    .rdata_o        (rdata_o)
  );

endmodule

// File: tb_clk_gen.sv
// clock and reset source for the load/store unit testbench, 40 ns period and a 5 cycle reset
module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_NS    = 20;  // half of the 40 ns period
  localparam int RST_CYCLES = 5;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_NS) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;  // released on a rising edge like the other inputs
  end

endmodule

// File: tb_lsu_mem.sv
// OBI memory responder for the load/store unit testbench, random grants and in-order responses
`include "lsu_config.svh"

module tb_lsu_mem
  import lsu_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [3:0]             rnd_i,             // [1:0] grant odds, [3:2] response delay
  input  logic                   bus_req_i,
  input  lsu_bus_req_t           bus_req_fields_i,
  output logic                   bus_gnt_o,
  output logic                   bus_rvalid_o,
  output logic [`LSU_DATA_W-1:0] bus_rdata_o
);
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    logic [`LSU_DATA_W-1:0] rdata;  // word as read at grant time
    logic [31:0]            due;    // first cycle the response may go out
  } rsp_t;

  logic [7:0]  mem [0:255];  // 256 bytes, upper address bits alias
  rsp_t        rsp_q[$];     // pending responses, oldest first
  logic [31:0] cyc;

  initial begin
    bus_gnt_o    = 1'b0;
    bus_rvalid_o = 1'b0;
    bus_rdata_o  = '0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = 8'(i) ^ 8'hA5;  // each address gets its own byte
    end
  end

  always @(posedge clk or negedge rst_n) begin
    logic [7:0] base;
    logic [1:0] delay;
    logic       rvalid_next;
    rsp_t       rsp;
    if (!rst_n) begin
      rsp_q.delete();
      cyc = '0;
      bus_gnt_o    <= 1'b0;
      bus_rvalid_o <= 1'b0;
      bus_rdata_o  <= '0;
    end else begin
      cyc = cyc + 32'd1;
      if (bus_rvalid_o) begin
        rsp_q.delete(0);  // went out in the cycle just ended
      end
      ////////////////////////////// address phase
      if (bus_req_i && bus_gnt_o) begin
        base = {bus_req_fields_i.addr[7:2], 2'b00};
        for (int i = 0; i < 4; i++) begin
          if (bus_req_fields_i.we && bus_req_fields_i.be[i]) begin
            mem[base + 8'(i)] = bus_req_fields_i.wdata[8*i +: 8];
          end
        end
        delay     = (rnd_i[3:2] == 2'd3) ? 2'd3 : rnd_i[3:2] + 2'd1;  // 1..3 cycles
        rsp.rdata = {mem[base + 8'd3], mem[base + 8'd2], mem[base + 8'd1], mem[base]};
        rsp.due   = cyc + 32'(delay) - 32'd1;
        rsp_q.push_back(rsp);
      end
      ////////////////////////////// next cycle
      rvalid_next = (rsp_q.size() > 0) && (cyc >= rsp_q[0].due);
      bus_rvalid_o <= rvalid_next;
      bus_rdata_o  <= rvalid_next ? rsp_q[0].rdata : ~cyc;  // junk between responses
      // grant in three cycles out of four, whatever is in flight
      bus_gnt_o <= (rnd_i[1:0] != 2'b00);
    end
  end

endmodule

// File: tb_lsu.sv
// testbench top of the load/store unit, random accesses checked against a byte memory model
`include "lsu_config.svh"

module tb_lsu
  import lsu_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_ACC = 200;  // accesses to run
  localparam int CLK_NS  = 40;
  localparam int RST_CYC = 5;

  typedef struct packed {
    logic                   is_load;  // store responses carry nothing to check
    logic [`LSU_DATA_W-1:0] value;
  } exp_rsp_t;

  logic                   clk;
  logic                   rst_n;
  logic                   ex_valid;
  lsu_ex_req_t            ex_req;
  logic                   ex_ready;
  logic                   bus_req;
  lsu_bus_req_t           bus_fields;
  logic                   bus_gnt;
  logic                   bus_rvalid;
  logic [`LSU_DATA_W-1:0] bus_rdata;
  logic [`LSU_DATA_W-1:0] rdata;
  logic                   wb_ready;
  logic                   busy;
  logic [3:0]             mem_rnd;      // random bits for the responder

  logic [15:0]            lfsr_q;
  logic [7:0]             model_mem [0:255];
  exp_rsp_t               exp_q[$];     // one entry per accepted access
  logic [`LSU_DATA_W-1:0] last_load;
  logic                   stall_q;      // request without grant last cycle
  lsu_bus_req_t           held_fields;
  int                     tb_cnt;       // in flight, from grants and responses
  int                     granted_only; // granted on the bus, not yet accepted by EX
  int                     n_acc;
  int                     n_checks;
  int                     errors;       // value mismatches
  int                     other_errors;

  tb_clk_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  lsu_top DUT (
    .clk              (clk),
    .rst_n            (rst_n),
    .ex_valid_i       (ex_valid),
    .ex_req_i         (ex_req),
    .ex_ready_o       (ex_ready),
    .bus_req_o        (bus_req),
    .bus_req_fields_o (bus_fields),
    .bus_gnt_i        (bus_gnt),
    .bus_rvalid_i     (bus_rvalid),
    .bus_rdata_i      (bus_rdata),
    .rdata_o          (rdata),
    .wb_ready_o       (wb_ready),
    .busy_o           (busy)
  );

  tb_lsu_mem u_mem (
    .clk              (clk),
    .rst_n            (rst_n),
    .rnd_i            (mem_rnd),
    .bus_req_i        (bus_req),
    .bus_req_fields_i (bus_fields),
    .bus_gnt_o        (bus_gnt),
    .bus_rvalid_o     (bus_rvalid),
    .bus_rdata_o      (bus_rdata)
  );

  //////////////////////////////
  // random numbers and model
  //////////////////////////////
  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic int size_bytes(input lsu_dtype_e dt);
    return (dt == DT_WORD) ? 4 : (dt == DT_HALF) ? 2 : 1;
  endfunction

  function automatic logic [31:0] eff_addr(input lsu_ex_req_t r);
    return r.use_incr ? r.op_a + r.op_b : r.op_a;
  endfunction

  // naturally aligned access inside the first 64 bytes, so stores and loads overlap
  function automatic lsu_ex_req_t random_req();
    lsu_ex_req_t r;
    logic [31:0] target;
    logic [1:0]  sel;
    r.we     = 1'(rand_bits(1));
    sel      = 2'(rand_bits(2));
    r.dtype  = (sel == 2'd3) ? DT_WORD : lsu_dtype_e'(sel);
    sel      = 2'(rand_bits(2));
    r.ext    = (sel == 2'd3) ? EXT_SIGN : lsu_ext_e'(sel);
    target   = rand_bits(32) & 32'hFFFF_FF3F;
    target   = target & ~32'(size_bytes(r.dtype) - 1);
    r.use_incr = 1'(rand_bits(1));
    r.op_b   = rand_bits(32);
    r.op_a   = r.use_incr ? target - r.op_b : target;
    r.wdata  = rand_bits(32);
    return r;
  endfunction

  function automatic logic [31:0] load_value(input lsu_ex_req_t r);
    logic [31:0] ea;
    logic [31:0] val;
    int          nb;
    ea  = eff_addr(r);
    nb  = size_bytes(r.dtype);
    val = '0;
    for (int i = 0; i < nb; i++) begin
      val[8*i +: 8] = model_mem[ea[7:0] + 8'(i)];
    end
    for (int i = 8 * nb; i < 32; i++) begin
      val[i] = (r.ext == EXT_ONES) || ((r.ext == EXT_SIGN) && val[8*nb-1]);
    end
    return val;
  endfunction

  task automatic store_model(input lsu_ex_req_t r);
    logic [31:0] ea;
    ea = eff_addr(r);
    for (int i = 0; i < size_bytes(r.dtype); i++) begin
      model_mem[ea[7:0] + 8'(i)] = r.wdata[8*i +: 8];
    end
  endtask

  //////////////////////////////
  // checks
  //////////////////////////////
  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  // address, enables and store lanes of a granted request
  task automatic check_addr_phase();
    logic [31:0] ea;
    logic [31:0] exp_w;
    logic [31:0] lane_mask;
    int          off;
    int          nb;
    ea        = eff_addr(ex_req);
    off       = int'(ea[1:0]);
    nb        = size_bytes(ex_req.dtype);
    exp_w     = '0;
    lane_mask = '0;
    for (int i = 0; i < nb; i++) begin
      exp_w[8*(i+off) +: 8]     = ex_req.wdata[8*i +: 8];
      lane_mask[8*(i+off) +: 8] = 8'hFF;
    end
    compare_value("bus_req_fields_o.addr", bus_fields.addr, ea);
    compare_value("bus_req_fields_o.we", 32'(bus_fields.we), 32'(ex_req.we));
    compare_value("bus_req_fields_o.be", 32'(bus_fields.be), 32'(((1 << nb) - 1) << off));
    if (ex_req.we) begin
      compare_value("bus_req_fields_o.wdata", bus_fields.wdata & lane_mask, exp_w);
    end
  endtask

  // runs on the rising edge, so every value read here is the one of the cycle just ended
  task automatic observe_cycle();
    exp_rsp_t rsp;
    if (stall_q) begin  // grant withheld last cycle
      compare_value("bus_req_o", 32'(bus_req), 32'd1);
      compare_value("bus_req_fields_o.addr", bus_fields.addr, held_fields.addr);
      compare_value("bus_req_fields_o.we", 32'(bus_fields.we), 32'(held_fields.we));
      compare_value("bus_req_fields_o.be", 32'(bus_fields.be), 32'(held_fields.be));
      compare_value("bus_req_fields_o.wdata", bus_fields.wdata, held_fields.wdata);
    end
    // request follows EX valid unless the window is full
    compare_value("bus_req_o", 32'(bus_req), 32'(ex_valid && (tb_cnt < `LSU_DEPTH)));
    compare_value("busy_o", 32'(busy), 32'((tb_cnt != 0) || bus_req));
    compare_value("wb_ready_o", 32'(wb_ready), (tb_cnt == 0) ? 32'd1 : 32'(bus_rvalid));
    if (ex_valid && bus_req && !bus_gnt) compare_value("ex_ready_o", 32'(ex_ready), 32'd0);
    if (bus_req && bus_gnt) check_addr_phase();
    // a grant at one in flight without a response is accepted with the next response
    granted_only = granted_only + int'(bus_req && bus_gnt) - int'(ex_valid && ex_ready);
    if (granted_only < 0 || granted_only > 1) begin
      other_errors++;
      $display("ERROR: bus grants and execute acceptances out of step at %0t", $time);
    end
    ////////////////////////////// response side
    if (bus_rvalid && exp_q.size() == 0) begin
      other_errors++;
      $display("ERROR: response arrived with no access outstanding at %0t", $time);
    end else if (bus_rvalid) begin
      rsp = exp_q.pop_front();
      if (rsp.is_load) begin
        compare_value("rdata_o", rdata, rsp.value);
        last_load = rsp.value;
      end
    end else begin
      compare_value("rdata_o", rdata, last_load);  // held between responses
    end
    ////////////////////////////// acceptance into the model
    if (ex_valid && ex_ready) begin
      if (ex_req.we) store_model(ex_req);
      exp_q.push_back({!ex_req.we, ex_req.we ? 32'd0 : load_value(ex_req)});
      n_acc++;
    end
    tb_cnt      = tb_cnt + int'(bus_req && bus_gnt) - int'(bus_rvalid);
    stall_q     = bus_req && !bus_gnt;
    held_fields = bus_fields;
  endtask

  task automatic drive_cycle();
    mem_rnd <= 4'(rand_bits(4));
    if (!ex_valid || ex_ready) begin  // request held until accepted
      if (n_acc < NUM_ACC && 2'(rand_bits(2)) != 2'b00) begin
        ex_valid <= 1'b1;
        ex_req   <= random_req();
      end else begin
        ex_valid <= 1'b0;
      end
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial begin
    lfsr_q       = 16'd43;
    last_load    = '0;
    stall_q      = 1'b0;
    held_fields  = '0;
    tb_cnt       = 0;
    granted_only = 0;
    n_acc        = 0;
    n_checks     = 0;
    errors       = 0;
    other_errors = 0;
    for (int i = 0; i < 256; i++) begin
      model_mem[i] = 8'(i) ^ 8'hA5;  // same contents the responder starts with
    end
    ex_valid = 1'b0;
    ex_req   = '0;
    mem_rnd  = '0;
    @(posedge rst_n);
    // the first pass checks the idle state right after reset
    while (n_acc < NUM_ACC || exp_q.size() > 0) begin
      @(posedge clk);
      observe_cycle();
      drive_cycle();
    end
    $display("accesses: %0d, checks: %0d, mismatches: %0d, other errors: %0d",
             n_acc, n_checks, errors, other_errors);
    if (errors == 0 && other_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // 12 cycles per access is far above the slowest random mix
  initial begin
    #((NUM_ACC * 12 + RST_CYC) * CLK_NS);
    $display("ERROR: run timed out after %0d cycles with %0d of %0d accesses done",
             NUM_ACC * 12 + RST_CYC, n_acc, NUM_ACC);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: project.f
+incdir+.
lsu_pkg.sv
lsu_req_gen.sv
lsu_txn_ctrl.sv
lsu_load_align.sv
lsu_top.sv
tb_clk_gen.sv
tb_lsu_mem.sv
tb_lsu.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/100ps -Wno-fatal
TOP       = tb_lsu
FILELIST  = project.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
